//--- include/spi_settings.svh
`ifndef SPI_SETTINGS_SVH
`define SPI_SETTINGS_SVH

// Register address bits
`define SPI_ADDR_W 3

// Write data and read data bits
`define SPI_DATA_W 8

// rw + addr + data
`define SPI_CMD_W (1 + `SPI_ADDR_W + `SPI_DATA_W)

// System clocks per sclk half period
`define SPI_SCLK_DIV 4

`endif

//--- design/spi_pkg.sv
`include "spi_settings.svh"

package spi_pkg;

  // Command word, shifted out MSB first
  typedef struct packed {
    logic                   rw;    // 1 write, 0 read
    logic [`SPI_ADDR_W-1:0] addr;
    logic [`SPI_DATA_W-1:0] data;  // Don't care on a read
  } spi_cmd_t;

  typedef logic [`SPI_DATA_W-1:0] spi_rdata_t;

  localparam int SPI_CMD_BITS  = `SPI_CMD_W;
  localparam int SPI_DATA_BITS = `SPI_DATA_W;

  // sclk rising edges per frame
  localparam int SPI_FRAME_WR = SPI_CMD_BITS;
  localparam int SPI_FRAME_RD = SPI_CMD_BITS + SPI_DATA_BITS;

  // Wide enough to hold the longest frame count
  localparam int SPI_CNT_W = $clog2(SPI_FRAME_RD + 1);

endpackage

//--- design/spi_bit_clock.sv
`timescale 1ns/1ns

`include "spi_settings.svh"

module spi_bit_clock #(
  parameter int SCLK_DIV = `SPI_SCLK_DIV
) (
  input  logic clk,
  input  logic rst_n,
  input  logic run,
  output logic sclk,
  output logic rise,
  output logic fall
);

  localparam int DIV_W = (SCLK_DIV > 2) ? $clog2(SCLK_DIV) : 1;

  logic [DIV_W-1:0] div_cnt;
  logic             div_tc;

  assign div_tc = (div_cnt == DIV_W'(SCLK_DIV - 1));  // Half period done

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      div_cnt <= '0;
      sclk    <= 1'b0;
      rise    <= 1'b0;
      fall    <= 1'b0;
    end
    else
    begin
      rise <= 1'b0;
      fall <= 1'b0;
      if (!run)
      begin
        div_cnt <= '0;   // Park low between frames
        sclk    <= 1'b0;
      end
      else if (div_tc)
      begin
        div_cnt <= '0;
        sclk    <= ~sclk;
        rise    <= ~sclk;  // Strobes line up with the new sclk level
        fall    <= sclk;
      end
      else
      begin
        div_cnt <= div_cnt + 1'b1;
      end
    end
  end

endmodule

//--- design/spi_cmd_engine.sv
`timescale 1ns/1ns

module spi_cmd_engine (
  input  logic               clk,
  input  logic               rst_n,
  input  spi_pkg::spi_cmd_t   cmd_in,
  input  logic               cmd_vld,
  output logic               cmd_rdy,
  input  logic               rise,
  input  logic               fall,
  output logic               run,
  output logic               cs,
  output logic               mosi,
  input  logic               miso,
  output logic               read_vld,
  output spi_pkg::spi_rdata_t read_data
);

  import spi_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_SEND,
    ST_RECV
  } state_t;

  state_t                  state_q;
  state_t                  state_d;
  logic [SPI_CMD_BITS-1:0] cmd_bits;
  logic [SPI_CMD_BITS-1:0] shift_q;
  spi_rdata_t              cap_q;
  logic [SPI_CNT_W-1:0]    rise_cnt_q;
  logic [SPI_CNT_W-1:0]    last_cnt;
  logic                    rd_q;
  logic                    accept;
  logic                    cmd_sent;
  logic                    frame_end;

  assign cmd_bits = cmd_in;
  assign cmd_rdy  = (state_q == ST_IDLE);
  assign accept   = cmd_vld && cmd_rdy;
  assign run      = ~cs;

  // Frame length follows the latched rw bit
  assign last_cnt = rd_q ? SPI_CNT_W'(SPI_FRAME_RD) : SPI_CNT_W'(SPI_FRAME_WR);

  // Fall after the last command bit was sampled
  assign cmd_sent  = fall && (rise_cnt_q == SPI_CNT_W'(SPI_FRAME_WR));
  assign frame_end = fall && (rise_cnt_q == last_cnt);

  always_comb
  begin
    state_d = state_q;
    case (state_q)
      ST_IDLE:
      begin
        if (accept)
        begin
          state_d = ST_SEND;
        end
      end
      ST_SEND:
      begin
        if (frame_end)
        begin
          state_d = ST_IDLE;   // Write frame done
        end
        else if (cmd_sent)
        begin
          state_d = ST_RECV;   // Read, turn around for miso
        end
      end
      ST_RECV:
      begin
        if (frame_end)
        begin
          state_d = ST_IDLE;
        end
      end
      default:
      begin
        state_d = ST_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state_q    <= ST_IDLE;
      cs         <= 1'b1;
      mosi       <= 1'b0;
      rise_cnt_q <= '0;
      rd_q       <= 1'b0;
      read_vld   <= 1'b0;
    end
    else
    begin
      state_q  <= state_d;
      read_vld <= 1'b0;
      if (accept)
      begin
        cs         <= 1'b0;
        rise_cnt_q <= '0;
        rd_q       <= ~cmd_in.rw;
        mosi       <= cmd_in.rw;   // MSB ready before the first rise
      end
      else if (state_q != ST_IDLE)
      begin
        if (rise)
        begin
          rise_cnt_q <= rise_cnt_q + 1'b1;
        end
        if (frame_end)
        begin
          cs       <= 1'b1;
          mosi     <= 1'b0;
          read_vld <= rd_q;
        end
        else if (state_q == ST_SEND && fall)
        begin
          mosi <= cmd_sent ? 1'b0 : shift_q[SPI_CMD_BITS-1];
        end
      end
    end
  end

  // Serial payload
  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      shift_q <= {cmd_bits[SPI_CMD_BITS-2:0], 1'b0};  // MSB already on mosi
    end
    else if (state_q == ST_SEND && fall)
    begin
      shift_q <= shift_q << 1;
    end

    if (state_q == ST_RECV && rise)
    begin
      cap_q <= {cap_q[SPI_DATA_BITS-2:0], miso};
    end

    if (frame_end && rd_q)
    begin
      read_data <= cap_q;   // Held until the next read
    end
  end

endmodule

//--- design/spi_ctrl_top.sv
`timescale 1ns/1ns

module spi_ctrl_top (
  input  logic               clk,
  input  logic               rst_n,
  input  spi_pkg::spi_cmd_t   cmd_in,
  input  logic               cmd_vld,
  output logic               cmd_rdy,
  output logic               sclk,
  output logic               cs,
  output logic               mosi,
  input  logic               miso,
  output logic               read_vld,
  output spi_pkg::spi_rdata_t read_data
);

  logic run;
  logic rise;
  logic fall;

  spi_cmd_engine u_engine (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .cmd_rdy   (cmd_rdy),
    .rise      (rise),
    .fall      (fall),
    .run       (run),
    .cs        (cs),
    .mosi      (mosi),
    .miso      (miso),
    .read_vld  (read_vld),
    .read_data (read_data)
  );

  // Divider from the settings default
  spi_bit_clock u_bit_clock (
    .clk   (clk),
    .rst_n (rst_n),
    .run   (run),
    .sclk  (sclk),
    .rise  (rise),
    .fall  (fall)
  );

endmodule

//--- sim/spi_dev_model.sv
`timescale 1ns/1ns

`include "spi_settings.svh"

module spi_dev_model (
  input  logic rst_n,
  input  logic sclk,
  input  logic cs,
  input  logic mosi,
  output logic miso,
  output int   rises
);

  import spi_pkg::*;

  localparam int NUM_REGS = 1 << `SPI_ADDR_W;

  spi_rdata_t              regs [0:NUM_REGS-1];
  logic [SPI_CMD_BITS-1:0] cmd_sr;
  spi_rdata_t              out_sr;

  task automatic clear_regs();
    for (int i = 0; i < NUM_REGS; i++)
    begin
      regs[i] = '0;
    end
  endtask

  // One cs-low frame, from the cs fall to the cs rise
  task automatic serve_frame();
    spi_cmd_t cmd;
    logic     is_read;
    rises   = 0;
    cmd_sr  = '0;
    is_read = 1'b0;
    while (!cs)
    begin
      @(posedge sclk or negedge sclk or posedge cs);
      if (!cs)
      begin
        if (sclk)
        begin
          rises = rises + 1;
          if (rises <= SPI_CMD_BITS)
          begin
            cmd_sr = {cmd_sr[SPI_CMD_BITS-2:0], mosi};  // MSB first
          end
          if (rises == SPI_CMD_BITS)
          begin
            cmd = spi_cmd_t'(cmd_sr);
            if (cmd.rw)
            begin
              regs[cmd.addr] = cmd.data;
            end
            else
            begin
              is_read = 1'b1;
              out_sr  = regs[cmd.addr];
            end
          end
        end
        else if (is_read && rises >= SPI_CMD_BITS && rises < SPI_FRAME_RD)
        begin
          miso   = out_sr[SPI_DATA_BITS-1];  // Changes on the fall
          out_sr = out_sr << 1;
        end
      end
    end
    miso = 1'b0;
  endtask

  initial
  begin
    miso  = 1'b0;
    rises = 0;
    clear_regs();
    forever
    begin
      @(negedge cs or negedge rst_n);
      if (!rst_n)
      begin
        clear_regs();
      end
      else
      begin
        serve_frame();
      end
    end
  end

endmodule

//--- sim/tb_spi.sv
`timescale 1ns/1ns

`include "spi_settings.svh"

module tb_spi;

  import spi_pkg::*;

  localparam int NUM_REGS     = 1 << `SPI_ADDR_W;
  localparam int NUM_RANDOM   = 64;
  localparam int NUM_BP       = 6;
  localparam int NUM_DIRECTED = 1 + 2 * NUM_REGS + NUM_BP;
  localparam int CYCLE_LIMIT  = 200 * (NUM_RANDOM + NUM_DIRECTED);
  localparam int WR_RISES     = `SPI_CMD_W;                // Command bits only
  localparam int RD_RISES     = `SPI_CMD_W + `SPI_DATA_W;  // Command plus read data

  logic        clk;
  logic        rst_n;
  spi_cmd_t    cmd_in;
  logic        cmd_vld;
  logic        cmd_rdy;
  logic        sclk;
  logic        cs;
  logic        mosi;
  logic        miso;
  logic        read_vld;
  spi_rdata_t  read_data;
  int          dev_rises;

  spi_rdata_t  mirror [0:NUM_REGS-1];
  spi_rdata_t  exp_q[$];
  logic        rw_q[$];
  string       name_q[$];
  int          error_count   = 0;
  int          accepted      = 0;
  int          frames        = 0;
  int          issued        = 0;
  logic        cs_prev       = 1'b1;
  logic        reset_checked = 1'b0;
  logic        stim_done     = 1'b0;
  logic        checks_done   = 1'b0;
  string       test_name     = "reset";
  logic [31:0] rng           = 32'd64;

  spi_ctrl_top UUT (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .cmd_rdy   (cmd_rdy),
    .sclk      (sclk),
    .cs        (cs),
    .mosi      (mosi),
    .miso      (miso),
    .read_vld  (read_vld),
    .read_data (read_data)
  );

  spi_dev_model dev (
    .rst_n (rst_n),
    .sclk  (sclk),
    .cs    (cs),
    .mosi  (mosi),
    .miso  (miso),
    .rises (dev_rises)
  );

  initial
  begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  function automatic logic [31:0] next_random(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // A write updates the mirror and a read returns its entry
  function automatic spi_rdata_t expected_read(input spi_cmd_t cmd);
    if (cmd.rw)
    begin
      mirror[cmd.addr] = cmd.data;
      return '0;
    end
    return mirror[cmd.addr];
  endfunction

  function automatic spi_cmd_t make_cmd(input logic rw, input logic [`SPI_ADDR_W-1:0] addr,
                                        input spi_rdata_t data);
    spi_cmd_t c;
    c.rw   = rw;
    c.addr = addr;
    c.data = data;
    return c;
  endfunction

  task automatic check_rdata(input string name, input spi_rdata_t exp, input spi_rdata_t act);
    if (act !== exp)
    begin
      error_count++;
      $display("Mismatch %s read data: expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic check_count(input string name, input int exp, input int act);
    if (act != exp)
    begin
      error_count++;
      $display("Mismatch %s: expected %0d actual %0d", name, exp, act);
    end
  endtask

  task automatic check_level(input string name, input logic exp, input logic act);
    if (act !== exp)
    begin
      error_count++;
      $display("Mismatch %s: expected %b actual %b", name, exp, act);
    end
  endtask

  // Called on a rising edge. With keep_vld it returns on the accepting edge,
  // otherwise cmd_vld drops and it returns once the frame is over
  task automatic issue_cmd(input spi_cmd_t cmd, input logic keep_vld);
    cmd_in  <= cmd;
    cmd_vld <= 1'b1;
    issued  = issued + 1;
    do
    begin
      @(negedge clk);
    end
    while (!cmd_rdy);
    @(posedge clk);
    if (!keep_vld)
    begin
      cmd_vld <= 1'b0;
      do
      begin
        @(negedge clk);
      end
      while (!cmd_rdy);
      @(posedge clk);
    end
  endtask

  initial
  begin
    rst_n   <= 1'b0;
    cmd_vld <= 1'b0;
    cmd_in  <= '0;
    for (int a = 0; a < NUM_REGS; a++)
    begin
      mirror[a] = '0;   // Device registers come out of reset as zero
    end
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;
    repeat (2) @(posedge clk);  // Reset state sampled first

    test_name = "unwritten";
    issue_cmd(make_cmd(1'b0, 3'd5, 8'h00), 1'b0);

    test_name = "write_read";
    for (int a = 0; a < NUM_REGS; a++)
    begin
      issue_cmd(make_cmd(1'b1, a[`SPI_ADDR_W-1:0], 8'(8'h11 * (a + 1))), 1'b0);
    end
    for (int a = 0; a < NUM_REGS; a++)
    begin
      issue_cmd(make_cmd(1'b0, a[`SPI_ADDR_W-1:0], 8'h00), 1'b0);
    end

    test_name = "random";
    for (int i = 0; i < NUM_RANDOM; i++)
    begin
      rng = next_random(rng);
      issue_cmd(spi_cmd_t'(rng[SPI_CMD_BITS-1:0]), 1'b0);
    end

    // cmd_vld stays high across whole frames
    test_name = "backpressure";
    for (int i = 0; i < NUM_BP; i++)
    begin
      rng = next_random(rng);
      issue_cmd(spi_cmd_t'(rng[SPI_CMD_BITS-1:0]), (i != NUM_BP - 1));
    end

    stim_done <= 1'b1;
  end

  always @(negedge clk)
  begin : compare_proc
    spi_rdata_t exp_val;
    logic       frame_rw;
    string      frame_name;
    if (rst_n && !checks_done)
    begin
      if (!reset_checked)
      begin
        check_level("reset cs", 1'b1, cs);
        check_level("reset sclk", 1'b0, sclk);
        check_level("reset mosi", 1'b0, mosi);
        check_level("reset read_vld", 1'b0, read_vld);
        check_level("reset cmd_rdy", 1'b1, cmd_rdy);
        reset_checked = 1'b1;
      end

      if (cmd_vld && cmd_rdy)
      begin
        accepted++;
        rw_q.push_back(cmd_in.rw);
        name_q.push_back(test_name);
        exp_val = expected_read(cmd_in);
        if (!cmd_in.rw)
        begin
          exp_q.push_back(exp_val);
        end
      end

      if (!cs && cmd_rdy)
      begin
        error_count++;
        $display("cmd_rdy was high while cs was low in test %s", test_name);
      end

      if (cs && !cs_prev)
      begin
        frames++;
        if (rw_q.size() == 0)
        begin
          error_count++;
          $display("A cs frame ended with no accepted command in test %s", test_name);
        end
        else
        begin
          frame_rw   = rw_q.pop_front();
          frame_name = name_q.pop_front();
          check_count({frame_name, " frame rises"},
                      frame_rw ? WR_RISES : RD_RISES, dev_rises);
        end
      end
      cs_prev = cs;

      if (read_vld)
      begin
        if (exp_q.size() == 0)
        begin
          error_count++;
          $display("read_vld pulsed with no read pending in test %s", test_name);
        end
        else
        begin
          check_rdata(frame_name, exp_q.pop_front(), read_data);
        end
      end

      if (stim_done)
      begin
        check_count("accepted commands", issued, accepted);
        check_count("cs frames", accepted, frames);
        if (exp_q.size() != 0)
        begin
          error_count++;
          $display("%0d accepted reads never returned data", exp_q.size());
        end
        checks_done = 1'b1;
      end
    end
  end

  initial
  begin : report
    wait (checks_done);
    $display("Errors: %0d, commands: %0d, frames: %0d", error_count, accepted, frames);
    if (error_count == 0)
    begin
      $display("Test OK");
    end
    else
    begin
      $display("Test FAILED");
    end
    $finish;
  end

  initial
  begin : watchdog
    int cycles;
    cycles = 0;
    while (cycles < CYCLE_LIMIT)
    begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
    $display("Test FAILED");
    $finish;
  end

endmodule

//--- tb.f
+incdir+include
design/spi_pkg.sv
design/spi_bit_clock.sv
design/spi_cmd_engine.sv
design/spi_ctrl_top.sv
sim/spi_dev_model.sv
sim/tb_spi.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_spi
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

SOURCES := $(wildcard design/*.sv sim/*.sv include/*.svh)

.PHONY: all build run lint clean

all: run

build: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "Test OK" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
